// ==== filelist.f ====
+incdir+hw
hw/key_unwrap_pkg.sv
hw/engine_if.sv
hw/feistel_decrypt.sv
hw/modexp_engine.sv
hw/unwrap_ctrl.sv
hw/key_unwrap_top.sv
verification/key_unwrap_tb.sv

// ==== hw/engine_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "key_unwrap_consts.svh"

interface engine_if;
	logic req;                     // four-phase request
	logic [`WORD_W-1:0] operand_a; // cipher block or base
	logic [`WORD_W-1:0] operand_b; // cipher key or modulus/exponent
	logic [`WORD_W-1:0] result;    // valid while ack is high
	logic ack;                     // four-phase acknowledge

	modport requester (
		output req,
		output operand_a,
		output operand_b,
		input  result,
		input  ack
	);

	modport engine (
		input  req,
		input  operand_a,
		input  operand_b,
		output result,
		output ack
	);
endinterface

`default_nettype wire

// ==== hw/feistel_decrypt.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "key_unwrap_consts.svh"

module feistel_decrypt (
	input  logic     clk,
	input  logic     rst,
	engine_if.engine bus
);
	localparam int HALF_W = `WORD_W / 2;
	localparam int RND_BITS = $clog2(`CIPHER_ROUNDS);

	logic busy_q;                        // rounds in progress
	logic start;                         // new request accepted
	logic [RND_BITS-1:0] round_q;        // counts down 7..0
	logic [HALF_W-1:0] left_q;
	logic [HALF_W-1:0] right_q;
	logic [`WORD_W-1:0] key_q;           // latched cipher key
	logic [2*`WORD_W-1:0] key_dbl;       // key twice, for rotation by slicing
	logic [`WORD_W-1:0] rot_base;        // slice start of the rotated key
	logic [HALF_W-1:0] round_key;
	logic [HALF_W-1:0] f_mix;
	logic [HALF_W-1:0] f_out;

	assign start = bus.req & ~bus.ack & ~busy_q; // only once per handshake

	// round key = low half of key rotated left by 4*round
	assign key_dbl = {key_q, key_q};
	assign rot_base = `WORD_W - {round_q, 2'b00};
	assign round_key = key_dbl[rot_base +: HALF_W];

	// F(h,k) = rotl3(h ^ k) + k
	assign f_mix = left_q ^ round_key;
	assign f_out = {f_mix[HALF_W-4:0], f_mix[HALF_W-1:HALF_W-3]} + round_key;

	assign bus.result = {left_q, right_q}; // plaintext once ack is up

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			round_q <= '0;
			bus.ack <= 1'b0;
		end else if (start) begin
			busy_q <= 1'b1;
			round_q <= RND_BITS'(`CIPHER_ROUNDS - 1); // decrypt runs last round first
		end else if (busy_q) begin
			round_q <= round_q - 1'b1;
			if (round_q == '0) begin
				busy_q <= 1'b0;
				bus.ack <= 1'b1; // held until req drops
			end
		end else if (!bus.req) begin
			bus.ack <= 1'b0; // close the handshake
		end
	end

	// halves and key carry no reset
	always_ff @(posedge clk) begin
		if (start) begin
			{left_q, right_q} <= bus.operand_a;
			key_q <= bus.operand_b;
		end else if (busy_q) begin
			// inverse round: old R = new L, old L = new R ^ F(new L)
			left_q <= right_q ^ f_out;
			right_q <= left_q;
		end
	end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(bus.ack) |-> bus.req);

endmodule

`default_nettype wire

// ==== hw/key_unwrap_consts.svh ====
`ifndef KEY_UNWRAP_CONSTS_SVH
`define KEY_UNWRAP_CONSTS_SVH

// vault word and cipher block width
`define WORD_W 32

// modulus, exponent, wrapped key and result width
`define KEY_W 16

// vault words expected after reset
`define VAULT_WORDS 2

// passphrase length limit in characters
`define PASS_LEN 4

// feistel round count
`define CIPHER_ROUNDS 8

// plaintext expected from vault word 0 under the right passphrase
`define CHECK_TAG 32'h5AFE_C0DE

`endif

// ==== hw/key_unwrap_pkg.sv ====
`default_nettype none

`include "key_unwrap_consts.svh"

package key_unwrap_pkg;

	// decrypted vault word 1, modulus in the upper half
	typedef struct packed {
		logic [`KEY_W-1:0] modulus;  // reduction modulus, must be >= 2
		logic [`KEY_W-1:0] exponent; // private exponent
	} key_fields_t;

	typedef union packed {
		logic [`WORD_W-1:0] raw; // as it leaves the cipher
		key_fields_t fields;     // as the modexp engine reads it
	} key_word_u;

	typedef enum logic [2:0] {
		LOAD,         // buffering vault words
		PASS,         // collecting passphrase chars
		CHECK,        // decrypt word 0, compare tag
		KEYDEC,       // decrypt word 1 into modulus/exponent
		WAIT_WRAPPED, // idle until next wrapped key
		UNWRAP,       // modexp on wrapped key
		SEND          // result waiting downstream
	} ctrl_state_e;

endpackage

`default_nettype wire

// ==== hw/key_unwrap_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "key_unwrap_consts.svh"

module key_unwrap_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall_i,
	input  logic [`WORD_W-1:0] vault_data_i,
	input  logic               vault_valid_i,
	output logic               vault_ready_o,
	input  logic [7:0]         kb_data_i,
	input  logic               kb_valid_i,
	input  logic               kb_enter_i,
	input  logic               kb_clear_i,
	input  logic [`KEY_W-1:0]  wrapped_data_i,
	input  logic               wrapped_valid_i,
	output logic               wrapped_ready_o,
	output logic [`KEY_W-1:0]  out_data_o,
	output logic               out_valid_o,
	input  logic               out_ready_i,
	output logic               led_pass_o,
	output logic               led_fail_o
);
	engine_if cipher_bus ();  // controller <-> feistel
	engine_if modexp_bus ();  // controller <-> modexp

	unwrap_ctrl i_ctrl (
		.clk             (clk),
		.rst             (rst),
		.stall_i         (stall_i),
		.vault_data_i    (vault_data_i),
		.vault_valid_i   (vault_valid_i),
		.vault_ready_o   (vault_ready_o),
		.kb_data_i       (kb_data_i),
		.kb_valid_i      (kb_valid_i),
		.kb_enter_i      (kb_enter_i),
		.kb_clear_i      (kb_clear_i),
		.wrapped_data_i  (wrapped_data_i),
		.wrapped_valid_i (wrapped_valid_i),
		.wrapped_ready_o (wrapped_ready_o),
		.out_data_o      (out_data_o),
		.out_valid_o     (out_valid_o),
		.out_ready_i     (out_ready_i),
		.led_pass_o      (led_pass_o),
		.led_fail_o      (led_fail_o),
		.cipher          (cipher_bus),
		.modexp          (modexp_bus)
	);

	feistel_decrypt i_cipher (
		.clk (clk),
		.rst (rst),
		.bus (cipher_bus)
	);

	modexp_engine i_modexp (
		.clk (clk),
		.rst (rst),
		.bus (modexp_bus)
	);

endmodule

`default_nettype wire

// ==== hw/modexp_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "key_unwrap_consts.svh"

module modexp_engine (
	input  logic     clk,
	input  logic     rst,
	engine_if.engine bus
);
	import key_unwrap_pkg::*;

	localparam int CNT_BITS = $clog2(`KEY_W);

	key_word_u key_in;                 // operand_b seen as modulus/exponent
	logic busy_q;
	logic start;
	logic [CNT_BITS-1:0] bit_cnt_q;    // exponent bits left, minus one
	logic [`KEY_W-1:0] mod_q;
	logic [`KEY_W-1:0] exp_q;          // shifts right each step
	logic [`KEY_W-1:0] base_q;         // b^(2^i) mod m
	logic [`KEY_W-1:0] acc_q;          // running result
	logic [2*`KEY_W-1:0] sq_full;
	logic [2*`KEY_W-1:0] mul_full;
	logic [2*`KEY_W-1:0] sq_rem;
	logic [2*`KEY_W-1:0] mul_rem;

	assign key_in.raw = bus.operand_b;
	assign start = bus.req & ~bus.ack & ~busy_q;

	// one square and one multiply per exponent bit
	assign sq_full = base_q * base_q;
	assign mul_full = acc_q * base_q;
	assign sq_rem = sq_full % {{`KEY_W{1'b0}}, mod_q};
	assign mul_rem = mul_full % {{`KEY_W{1'b0}}, mod_q};

	assign bus.result = {{(`WORD_W - `KEY_W){1'b0}}, acc_q};

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			bit_cnt_q <= '0;
			bus.ack <= 1'b0;
		end else if (start) begin
			busy_q <= 1'b1;
			bit_cnt_q <= CNT_BITS'(`KEY_W - 1);
		end else if (busy_q) begin
			bit_cnt_q <= bit_cnt_q - 1'b1;
			if (bit_cnt_q == '0) begin
				busy_q <= 1'b0;
				bus.ack <= 1'b1; // all exponent bits consumed
			end
		end else if (!bus.req) begin
			bus.ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mod_q <= key_in.fields.modulus;
			exp_q <= key_in.fields.exponent;
			base_q <= bus.operand_a[`KEY_W-1:0]; // reduced by the first square
			acc_q <= `KEY_W'(1);                 // 1 mod m, m >= 2
		end else if (busy_q) begin
			if (exp_q[0])
				acc_q <= mul_rem[`KEY_W-1:0];
			base_q <= sq_rem[`KEY_W-1:0];
			exp_q <= exp_q >> 1;
		end
	end

	a_mod_nonzero: assert property (@(posedge clk) disable iff (rst)
		busy_q |-> mod_q != '0);

endmodule

`default_nettype wire

// ==== hw/unwrap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "key_unwrap_consts.svh"

module unwrap_ctrl (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall_i,
	input  logic [`WORD_W-1:0] vault_data_i,
	input  logic               vault_valid_i,
	output logic               vault_ready_o,
	input  logic [7:0]         kb_data_i,
	input  logic               kb_valid_i,
	input  logic               kb_enter_i,
	input  logic               kb_clear_i,
	input  logic [`KEY_W-1:0]  wrapped_data_i,
	input  logic               wrapped_valid_i,
	output logic               wrapped_ready_o,
	output logic [`KEY_W-1:0]  out_data_o,
	output logic               out_valid_o,
	input  logic               out_ready_i,
	output logic               led_pass_o,
	output logic               led_fail_o,
	engine_if.requester        cipher,
	engine_if.requester        modexp
);
	import key_unwrap_pkg::*;

	localparam int VAULT_BITS = $clog2(`VAULT_WORDS);
	localparam int PASS_BITS = $clog2(`PASS_LEN);

	ctrl_state_e state_q;
	logic vault_rdy_q;
	logic wrapped_rdy_q;
	logic [VAULT_BITS-1:0] vault_cnt_q;
	logic [`WORD_W-1:0] vault_q [`VAULT_WORDS]; // encrypted tag word, encrypted key word
	logic [PASS_BITS-1:0] pass_cnt_q;
	logic [`WORD_W-1:0] pass_key_q;             // chars packed from the LSB
	key_word_u key_word_q;                      // decrypted modulus/exponent
	logic [`KEY_W-1:0] wrapped_q;
	logic vault_xfer;
	logic wrapped_xfer;
	logic cipher_free;
	logic cipher_done;
	logic modexp_free;
	logic modexp_done;

	// a stalled block accepts nothing
	assign vault_ready_o = vault_rdy_q & ~stall_i;
	assign wrapped_ready_o = wrapped_rdy_q & ~stall_i;
	assign vault_xfer = vault_valid_i & vault_ready_o;
	assign wrapped_xfer = wrapped_valid_i & wrapped_ready_o;

	assign cipher_free = ~cipher.req & ~cipher.ack; // last handshake closed
	assign cipher_done = cipher.req & cipher.ack;
	assign modexp_free = ~modexp.req & ~modexp.ack;
	assign modexp_done = modexp.req & modexp.ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= LOAD;
			vault_rdy_q <= 1'b1; // vault accepted right after reset
			wrapped_rdy_q <= 1'b0;
			vault_cnt_q <= '0;
			pass_cnt_q <= '0;
			pass_key_q <= '0;
			led_pass_o <= 1'b0;
			led_fail_o <= 1'b0;
			out_valid_o <= 1'b0;
			cipher.req <= 1'b0;
			modexp.req <= 1'b0;
		end else if (!stall_i) begin
			case (state_q)
				LOAD: if (vault_xfer) begin
					vault_cnt_q <= vault_cnt_q + 1'b1;
					if (vault_cnt_q == VAULT_BITS'(`VAULT_WORDS - 1)) begin
						vault_rdy_q <= 1'b0; // vault full, never reopens
						state_q <= PASS;
					end
				end
				PASS: if (kb_valid_i) begin
					if (kb_clear_i) begin
						pass_key_q <= '0;
						pass_cnt_q <= '0;
					end else if (kb_enter_i) begin
						state_q <= CHECK; // enter char itself not stored
					end else begin
						pass_key_q[{pass_cnt_q, 3'b000} +: 8] <= kb_data_i;
						pass_cnt_q <= pass_cnt_q + 1'b1; // wraps to 0 after last char
						if (pass_cnt_q == PASS_BITS'(`PASS_LEN - 1))
							state_q <= CHECK;
					end
				end
				CHECK: if (cipher_free) begin
					cipher.req <= 1'b1;
				end else if (cipher_done) begin
					cipher.req <= 1'b0;
					if (cipher.result == `CHECK_TAG) begin
						led_pass_o <= 1'b1;
						led_fail_o <= 1'b0;
						state_q <= KEYDEC;
					end else begin
						led_fail_o <= 1'b1;
						pass_key_q <= '0; // fresh entry
						pass_cnt_q <= '0;
						state_q <= PASS;
					end
				end
				KEYDEC: if (cipher_free) begin
					cipher.req <= 1'b1; // waits out the CHECK ack
				end else if (cipher_done) begin
					cipher.req <= 1'b0;
					wrapped_rdy_q <= 1'b1;
					state_q <= WAIT_WRAPPED;
				end
				WAIT_WRAPPED: if (wrapped_xfer) begin
					wrapped_rdy_q <= 1'b0; // one key in flight
					state_q <= UNWRAP;
				end
				UNWRAP: if (modexp_free) begin
					modexp.req <= 1'b1;
				end else if (modexp_done) begin
					modexp.req <= 1'b0;
					out_valid_o <= 1'b1;
					state_q <= SEND;
				end
				SEND: if (out_ready_i) begin
					out_valid_o <= 1'b0;
					wrapped_rdy_q <= 1'b1;
					state_q <= WAIT_WRAPPED;
				end
				default: state_q <= LOAD;
			endcase
		end
	end

	// data path, operands launched with req
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			if (state_q == LOAD && vault_xfer)
				vault_q[vault_cnt_q] <= vault_data_i;
			if (state_q == CHECK && cipher_free) begin
				cipher.operand_a <= vault_q[0];
				cipher.operand_b <= pass_key_q;
			end
			if (state_q == KEYDEC && cipher_free) begin
				cipher.operand_a <= vault_q[`VAULT_WORDS-1];
				cipher.operand_b <= pass_key_q;
			end
			if (state_q == KEYDEC && cipher_done)
				key_word_q.raw <= cipher.result;
			if (state_q == WAIT_WRAPPED && wrapped_xfer)
				wrapped_q <= wrapped_data_i;
			if (state_q == UNWRAP && modexp_free) begin
				modexp.operand_a <= {{(`WORD_W - `KEY_W){1'b0}}, wrapped_q};
				modexp.operand_b <= key_word_q.raw; // engine splits the fields
			end
			if (state_q == UNWRAP && modexp_done)
				out_data_o <= modexp.result[`KEY_W-1:0];
		end
	end

	// engine handshakes stay four-phase across both modules
	a_cipher_req_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(cipher.req) |-> !$past(cipher.ack));
	a_modexp_req_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(modexp.req) |-> !$past(modexp.ack));
	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it; exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module key_unwrap_tb -o key_unwrap_sim \
	&& ./obj_dir/key_unwrap_sim \
	|| { echo "build or simulation returned an error"; exit 1; }

// ==== verification/key_unwrap_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "key_unwrap_consts.svh"

module key_unwrap_tb;
	localparam int TIMEOUT = 200;                       // cycles allowed per wait
	localparam int N_PASS = 2;
	localparam int N_KEYS = 6;
	localparam logic [15:0] MODULUS = 16'hF1D3;
	localparam logic [15:0] EXPONENT = 16'h8A5B;
	localparam logic [31:0] GOOD_PASS = 32'h2179_334B; // "K3y!" packed from the LSB

	logic clk;
	logic rst;
	logic stall_i;
	logic [`WORD_W-1:0] vault_data_i;
	logic vault_valid_i;
	logic vault_ready_o;
	logic [7:0] kb_data_i;
	logic kb_valid_i;
	logic kb_enter_i;
	logic kb_clear_i;
	logic [`KEY_W-1:0] wrapped_data_i;
	logic wrapped_valid_i;
	logic wrapped_ready_o;
	logic [`KEY_W-1:0] out_data_o;
	logic out_valid_o;
	logic out_ready_i;
	logic led_pass_o;
	logic led_fail_o;

	// passphrase entries, applied in order
	string pass_name [N_PASS] = '{"wrong_pass", "clear_then_pass"};
	logic [31:0] pass_chars [N_PASS] = '{32'h0000_334B, GOOD_PASS};
	int pass_len [N_PASS] = '{2, 4};                  // short entry ends with enter
	bit pass_clear [N_PASS] = '{1'b0, 1'b1};          // junk chars then clear first
	bit pass_expect [N_PASS] = '{1'b0, 1'b1};         // 1 = led_pass expected
	logic [15:0] wrapped_keys [N_KEYS] = '{16'h0000, 16'h0001, 16'h1234,
		16'hF1D2, 16'hFFFF, 16'h7A3C};                // zero, one, m-1, above m

	logic [31:0] rng_state = 32'd36996;
	logic [31:0] vault [`VAULT_WORDS];

	key_unwrap_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int random_delay(input int n);
		rng_state = xorshift32(rng_state);
		return int'(rng_state % n);
	endfunction

	// forward cipher, rounds 0..7
	function automatic logic [31:0] feistel_encrypt(input logic [31:0] blk, input logic [31:0] key);
		logic [15:0] l;
		logic [15:0] r;
		logic [15:0] rk;
		logic [15:0] mix;
		logic [15:0] t;
		logic [31:0] rot;
		int i;
		l = blk[31:16];
		r = blk[15:0];
		for (i = 0; i < `CIPHER_ROUNDS; i++) begin
			rot = (key << (4 * i)) | (key >> (32 - 4 * i)); // shift by 32 gives 0
			rk = rot[15:0];
			mix = r ^ rk;
			t = l ^ ({mix[12:0], mix[15:13]} + rk);
			l = r;
			r = t;
		end
		return {l, r};
	endfunction

	// msb-first square and multiply
	function automatic logic [15:0] modexp_ref(input logic [15:0] b, input logic [15:0] e,
		input logic [15:0] m);
		logic [31:0] acc;
		int i;
		acc = 32'd1;
		for (i = 15; i >= 0; i--) begin
			acc = (acc * acc) % m;
			if (e[i])
				acc = (acc * b) % m;
		end
		return acc[15:0];
	endfunction

	// one keyboard strobe, one cycle wide
	task automatic kb_send(input logic [7:0] data, input logic enter, input logic clear);
		@(negedge clk);
		kb_valid_i = 1'b1;
		kb_data_i = data;
		kb_enter_i = enter;
		kb_clear_i = clear;
		@(negedge clk);
		kb_valid_i = 1'b0;
		kb_enter_i = 1'b0;
		kb_clear_i = 1'b0;
	endtask

	task automatic wait_vault_ready();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				abort_run("vault word was never accepted");
		end while (!vault_ready_o);
	endtask

	task automatic wait_led(input logic fail_before);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				abort_run("no LED reaction to the passphrase");
		end while (!(led_pass_o || (led_fail_o != fail_before))); // pass, or fail LED moved
	endtask

	task automatic wait_wrapped_ready();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				abort_run("wrapped key stream never became ready");
		end while (!wrapped_ready_o);
	endtask

	task automatic wait_out_valid();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			check_value("no_accept_while_busy", 0, wrapped_ready_o);
			if (cycles > TIMEOUT)
				abort_run("unwrapped result never appeared");
		end while (!out_valid_o);
	endtask

	initial begin
		int i;
		int n;
		int gap;
		logic fail_before;
		logic [15:0] expected;
		rst = 1'b1;
		stall_i = 1'b0;
		vault_data_i = '0;
		vault_valid_i = 1'b0;
		kb_data_i = '0;
		kb_valid_i = 1'b0;
		kb_enter_i = 1'b0;
		kb_clear_i = 1'b0;
		wrapped_data_i = '0;
		wrapped_valid_i = 1'b0;
		out_ready_i = 1'b0;
		vault[0] = feistel_encrypt(`CHECK_TAG, GOOD_PASS);
		vault[1] = feistel_encrypt({MODULUS, EXPONENT}, GOOD_PASS);
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(posedge clk);
		check_value("reset_vault_ready", 1, vault_ready_o);
		check_value("reset_wrapped_ready", 0, wrapped_ready_o);
		check_value("reset_out_valid", 0, out_valid_o);
		check_value("reset_led_pass", 0, led_pass_o);
		check_value("reset_led_fail", 0, led_fail_o);
		check_value("reset_cipher_req", 0, i_dut.cipher_bus.req);
		check_value("reset_modexp_req", 0, i_dut.modexp_bus.req);
		@(negedge clk);
		stall_i = 1'b1; // word offered while frozen
		vault_valid_i = 1'b1;
		vault_data_i = vault[0];
		repeat (6) begin
			@(posedge clk);
			check_value("stall_vault_ready", 0, vault_ready_o);
		end
		@(negedge clk);
		stall_i = 1'b0;
		wait_vault_ready();
		@(negedge clk);
		vault_data_i = vault[1];
		wait_vault_ready();
		@(negedge clk);
		vault_data_i = 32'hDEAD_BEEF; // third word must be refused
		repeat (8) begin
			@(posedge clk);
			check_value("vault_full_ready", 0, vault_ready_o);
		end
		@(negedge clk);
		vault_valid_i = 1'b0;
		for (i = 0; i < N_PASS; i++) begin
			fail_before = led_fail_o;
			if (pass_clear[i]) begin
				kb_send(8'h78, 1'b0, 1'b0);
				kb_send(8'h71, 1'b0, 1'b0);
				kb_send(8'h00, 1'b0, 1'b1);
			end
			for (n = 0; n < pass_len[i]; n++)
				kb_send(pass_chars[i][8*n +: 8], 1'b0, 1'b0);
			if (pass_len[i] < `PASS_LEN)
				kb_send(8'h0D, 1'b1, 1'b0);
			wait_led(fail_before);
			check_value({pass_name[i], "_led_pass"}, pass_expect[i], led_pass_o);
			check_value({pass_name[i], "_led_fail"}, !pass_expect[i], led_fail_o);
		end
		wait_wrapped_ready(); // key word decrypted, stream opens
		gap = random_delay(3);
		repeat (gap) @(negedge clk);
		@(negedge clk);
		wrapped_valid_i = 1'b1;
		wrapped_data_i = wrapped_keys[0];
		for (i = 0; i < N_KEYS; i++) begin
			expected = modexp_ref(wrapped_keys[i], EXPONENT, MODULUS);
			wait_wrapped_ready(); // valid high, so this edge transfers key i
			@(negedge clk);
			wrapped_valid_i = 1'b0;
			if (i + 1 < N_KEYS) begin
				gap = random_delay(3);
				repeat (gap) begin
					@(posedge clk);
					check_value("no_accept_while_busy", 0, wrapped_ready_o);
					@(negedge clk);
				end
				wrapped_valid_i = 1'b1; // next key waits behind the pending one
				wrapped_data_i = wrapped_keys[i+1];
			end
			wait_out_valid();
			check_value($sformatf("unwrap_%0d", i), expected, out_data_o);
			gap = random_delay(5);
			repeat (gap) begin
				@(posedge clk);
				check_value($sformatf("hold_valid_%0d", i), 1, out_valid_o);
				check_value($sformatf("hold_data_%0d", i), expected, out_data_o);
				check_value("no_accept_while_busy", 0, wrapped_ready_o);
			end
			@(negedge clk);
			out_ready_i = 1'b1;
			@(posedge clk);
			check_value($sformatf("xfer_data_%0d", i), expected, out_data_o);
			@(negedge clk);
			out_ready_i = 1'b0;
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
